/* rp_adc_frontend.sv */
// ADC input stage
`timescale 1ns/1ps
`include "rp_config.svh"

module rp_adc_frontend
  import rp_analog_pkg::*;
(
  input  logic       adc_clk,
  input  logic       arst_n_i,
  input  raw_pair_t  raw_i,            // straight from the pins
  input  chan_pair_t loop_i,           // saturated DAC sum
  input  logic       digital_loop_i,
  output chan_pair_t sample_o
);

  raw_pair_t raw_q;   // meant for the IO block registers

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      raw_q <= '0;
    else
      raw_q <= raw_i;
  end

  // neg slope to two's complement and loop-back select after the registers
  assign sample_o = digital_loop_i ? loop_i
                                   : chan_pair_t'{a: to_sample(raw_q.a), b: to_sample(raw_q.b)};

endmodule : rp_adc_frontend

/* rp_analog_pkg.sv */
// analog data path types
`include "rp_config.svh"

package rp_analog_pkg;

  typedef logic signed [`RP_DW-1:0] sample_t;   // two's complement

  // pin codes, unsigned with negative slope
  typedef struct packed {
    logic [`RP_DW-1:0] a;
    logic [`RP_DW-1:0] b;
  } raw_pair_t;

  typedef struct packed {
    sample_t a;
    sample_t b;
  } chan_pair_t;

  // pin code to sample, msb kept and the rest inverted
  function automatic sample_t to_sample(input logic [`RP_DW-1:0] raw);
    return {raw[`RP_DW-1], ~raw[`RP_DW-2:0]};
  endfunction

  // same rule in the other direction
  function automatic logic [`RP_DW-1:0] to_raw(input sample_t s);
    return {s[`RP_DW-1], ~s[`RP_DW-2:0]};
  endfunction

  // clamp any wider signed value into the sample range
  function automatic sample_t sat_sample(input logic signed [31:0] x);
    logic signed [31:0] hi;
    logic signed [31:0] lo;
    hi = 2 ** (`RP_DW - 1) - 1;   // +8191
    lo = -hi - 1;                 // -8192
    if (x > hi)
      return hi[`RP_DW-1:0];
    else if (x < lo)
      return lo[`RP_DW-1:0];
    return x[`RP_DW-1:0];
  endfunction

endpackage : rp_analog_pkg

/* rp_bus_pkg.sv */
// system bus types
`include "rp_config.svh"

package rp_bus_pkg;

  // request from the single master
  // addr and wdata held until ack
  typedef struct packed {
    logic [`RP_AW-1:0] addr;    // byte address
    logic [`RP_BW-1:0] wdata;   // whole word only, no byte selects
    logic              wen;     // one cycle pulse
    logic              ren;     // one cycle pulse
  } sys_req_t;

  // slave answer
  // rdata only valid while ack is high
  typedef struct packed {
    logic [`RP_BW-1:0] rdata;   // read data
    logic              err;     // never set here
    logic              ack;     // one cycle strobe
  } sys_rsp_t;

endpackage : rp_bus_pkg

/* rp_config.svh */
// shared widths and register map
`ifndef RP_CONFIG_SVH
`define RP_CONFIG_SVH

////////////////////////////////////////
// data path and bus widths
////////////////////////////////////////
`define RP_DW        14              // sample width
`define RP_AW        32              // bus address
`define RP_BW        32              // bus data
`define RP_KP_W      12              // controller gain
`define RP_KP_SHIFT  8               // gain is fixed point, 8 fraction bits

////////////////////////////////////////
// address space
////////////////////////////////////////
`define RP_REGIONS   8               // regions on addr[22:20]
`define RP_REG_MSB   22
`define RP_REG_LSB   20
`define RP_OFS_W     20              // offset inside a region
`define RP_REG_HK    0               // housekeeping
`define RP_REG_LVL   2               // level generator
`define RP_REG_CTL   3               // proportional controller

// register offsets
`define RP_OFS_HK_ID    20'h00000    // read only
`define RP_OFS_HK_LOOP  20'h00004
`define RP_OFS_HK_LED   20'h00008
`define RP_OFS_LVL_A    20'h00000
`define RP_OFS_LVL_B    20'h00004
`define RP_OFS_SP_A     20'h00000
`define RP_OFS_KP_A     20'h00004
`define RP_OFS_SP_B     20'h00008
`define RP_OFS_KP_B     20'h0000C

`define RP_HK_ID     32'h5250_0001   // board ID word

`endif

/* rp_dac_backend.sv */
// DAC output stage
`timescale 1ns/1ps
`include "rp_config.svh"

module rp_dac_backend
  import rp_analog_pkg::*;
(
  input  logic       adc_clk,
  input  logic       arst_n_i,
  input  chan_pair_t level_i,   // generator
  input  chan_pair_t ctrl_i,    // controller
  output chan_pair_t sum_o,     // unregistered, also the loop-back
  output raw_pair_t  raw_o      // to the DAC pins
);

  // zero in neg slope code, 0x1FFF
  localparam raw_pair_t RAW_ZERO = '{a: to_raw('0), b: to_raw('0)};

  logic signed [`RP_DW:0] sum_a, sum_b;   // one guard bit

  ////////////////////////////////////////
  // summing point
  ////////////////////////////////////////
  assign sum_a = level_i.a + ctrl_i.a;
  assign sum_b = level_i.b + ctrl_i.b;

  // clamp to +8191 / -8192 when the guard bit disagrees
  assign sum_o.a = sat_sample(sum_a);
  assign sum_o.b = sat_sample(sum_b);

  // back to pin code and register
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      raw_o <= RAW_ZERO;
    else
    begin
      raw_o.a <= to_raw(sum_o.a);
      raw_o.b <= to_raw(sum_o.b);
    end
  end

endmodule : rp_dac_backend

/* rp_housekeeping.sv */
// housekeeping registers
`timescale 1ns/1ps
`include "rp_config.svh"

module rp_housekeeping
  import rp_bus_pkg::*;
(
  input  logic     adc_clk,
  input  logic     arst_n_i,
  input  sys_req_t sys_req_i,
  output sys_rsp_t sys_rsp_o,
  output logic [7:0] led_o,
  output logic     digital_loop_o   // ADC input replaced by DAC sum
);

  logic [`RP_OFS_W-1:0] ofs;
  logic [7:0]           led_q;
  logic                 loop_q;
  logic [`RP_BW-1:0]    rd_data;    // read mux
  sys_rsp_t             rsp_q;

  assign ofs = sys_req_i.addr[`RP_OFS_W-1:0];

  ////////////////////////////////////////
  // write side
  ////////////////////////////////////////
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      led_q  <= '0;
      loop_q <= 1'b0;
    end
    else if (sys_req_i.wen)
    begin
      case (ofs)
        `RP_OFS_HK_LOOP: loop_q <= sys_req_i.wdata[0];
        `RP_OFS_HK_LED:  led_q  <= sys_req_i.wdata[7:0];
        default: ;   // ID write is acked, nothing stored
      endcase
    end
  end

  // read side
  always_comb
  begin
    rd_data = '0;
    case (ofs)
      `RP_OFS_HK_ID:   rd_data        = `RP_HK_ID;
      `RP_OFS_HK_LOOP: rd_data[0]     = loop_q;
      `RP_OFS_HK_LED:  rd_data[7:0]   = led_q;
      default: ;
    endcase
  end

  // answer one cycle after the strobe
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      rsp_q <= '0;
    else
    begin
      rsp_q.ack <= sys_req_i.wen | sys_req_i.ren;
      rsp_q.err <= 1'b0;
      if (sys_req_i.ren)
        rsp_q.rdata <= rd_data;
    end
  end

  assign sys_rsp_o      = rsp_q;
  assign led_o          = led_q;
  assign digital_loop_o = loop_q;

endmodule : rp_housekeeping

/* rp_level_gen.sv */
// DC level generator
`timescale 1ns/1ps
`include "rp_config.svh"

module rp_level_gen
  import rp_bus_pkg::*, rp_analog_pkg::*;
(
  input  logic       adc_clk,
  input  logic       arst_n_i,
  input  sys_req_t   sys_req_i,
  output sys_rsp_t   sys_rsp_o,
  output chan_pair_t level_o   // one constant per channel
);

  logic [`RP_OFS_W-1:0] ofs;
  chan_pair_t           level_q;
  logic [`RP_BW-1:0]    rd_data;
  sys_rsp_t             rsp_q;

  assign ofs = sys_req_i.addr[`RP_OFS_W-1:0];

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      level_q <= '0;
    else if (sys_req_i.wen)
    begin
      case (ofs)
        `RP_OFS_LVL_A: level_q.a <= sys_req_i.wdata[`RP_DW-1:0];   // low bits only
        `RP_OFS_LVL_B: level_q.b <= sys_req_i.wdata[`RP_DW-1:0];
        default: ;
      endcase
    end
  end

  // sign extended read back
  always_comb
  begin
    case (ofs)
      `RP_OFS_LVL_A: rd_data = {{(`RP_BW-`RP_DW){level_q.a[`RP_DW-1]}}, level_q.a};
      `RP_OFS_LVL_B: rd_data = {{(`RP_BW-`RP_DW){level_q.b[`RP_DW-1]}}, level_q.b};
      default:       rd_data = '0;
    endcase
  end

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      rsp_q <= '0;
    else
    begin
      rsp_q.ack <= sys_req_i.wen | sys_req_i.ren;   // 1 cycle latency
      rsp_q.err <= 1'b0;
      if (sys_req_i.ren)
        rsp_q.rdata <= rd_data;
    end
  end

  assign sys_rsp_o = rsp_q;
  assign level_o   = level_q;

endmodule : rp_level_gen

/* rp_prop_ctrl.sv */
// proportional controller
`timescale 1ns/1ps
`include "rp_config.svh"

module rp_prop_ctrl
  import rp_bus_pkg::*, rp_analog_pkg::*;
(
  input  logic       adc_clk,
  input  logic       arst_n_i,
  input  sys_req_t   sys_req_i,
  output sys_rsp_t   sys_rsp_o,
  input  chan_pair_t sample_i,   // from the ADC front end
  output chan_pair_t ctrl_o      // registered P term
);

  logic [`RP_OFS_W-1:0]      ofs;
  chan_pair_t                sp_q;          // setpoints
  logic signed [`RP_KP_W-1:0] kp_a_q, kp_b_q;
  logic [`RP_BW-1:0]         rd_data;
  sys_rsp_t                  rsp_q;

  // kp * (sp - x) >>> shift, clamped
  function automatic sample_t p_term(input sample_t sp, input sample_t x,
                                     input logic signed [`RP_KP_W-1:0] kp);
    logic signed [`RP_DW:0]          err;    // 15 bit error
    logic signed [`RP_DW+`RP_KP_W:0] prod;   // full product
    logic signed [31:0]              shifted;
    err     = sp - x;
    prod    = err * kp;
    shifted = prod >>> `RP_KP_SHIFT;         // drop fraction bits
    return sat_sample(shifted);
  endfunction

  assign ofs = sys_req_i.addr[`RP_OFS_W-1:0];

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      sp_q   <= '0;
      kp_a_q <= '0;
      kp_b_q <= '0;
    end
    else if (sys_req_i.wen)
    begin
      case (ofs)
        `RP_OFS_SP_A: sp_q.a <= sys_req_i.wdata[`RP_DW-1:0];
        `RP_OFS_KP_A: kp_a_q <= sys_req_i.wdata[`RP_KP_W-1:0];
        `RP_OFS_SP_B: sp_q.b <= sys_req_i.wdata[`RP_DW-1:0];
        `RP_OFS_KP_B: kp_b_q <= sys_req_i.wdata[`RP_KP_W-1:0];
        default: ;
      endcase
    end
  end

  always_comb
  begin
    case (ofs)
      `RP_OFS_SP_A: rd_data = {{(`RP_BW-`RP_DW){sp_q.a[`RP_DW-1]}}, sp_q.a};
      `RP_OFS_KP_A: rd_data = {{(`RP_BW-`RP_KP_W){kp_a_q[`RP_KP_W-1]}}, kp_a_q};
      `RP_OFS_SP_B: rd_data = {{(`RP_BW-`RP_DW){sp_q.b[`RP_DW-1]}}, sp_q.b};
      `RP_OFS_KP_B: rd_data = {{(`RP_BW-`RP_KP_W){kp_b_q[`RP_KP_W-1]}}, kp_b_q};
      default:      rd_data = '0;
    endcase
  end

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rsp_q  <= '0;
      ctrl_o <= '0;
    end
    else
    begin
      rsp_q.ack <= sys_req_i.wen | sys_req_i.ren;
      rsp_q.err <= 1'b0;
      if (sys_req_i.ren)
        rsp_q.rdata <= rd_data;
      ctrl_o.a <= p_term(sp_q.a, sample_i.a, kp_a_q);   // new sample every cycle
      ctrl_o.b <= p_term(sp_q.b, sample_i.b, kp_b_q);
    end
  end

  assign sys_rsp_o = rsp_q;

endmodule : rp_prop_ctrl

/* rp_sys_decoder.sv */
// system bus region decoder
`timescale 1ns/1ps
`include "rp_config.svh"

module rp_sys_decoder
  import rp_bus_pkg::*;
(
  input  sys_req_t sys_req_i,   // from the master
  output sys_rsp_t sys_rsp_o,
  output sys_req_t hk_req_o,    // region 0
  input  sys_rsp_t hk_rsp_i,
  output sys_req_t lvl_req_o,   // region 2
  input  sys_rsp_t lvl_rsp_i,
  output sys_req_t ctl_req_o,   // region 3
  input  sys_rsp_t ctl_rsp_i
);

  logic [2:0]             region;   // addr[22:20]
  logic [`RP_REGIONS-1:0] cs;       // one-hot select
  sys_rsp_t               rsp [`RP_REGIONS];

  assign region = sys_req_i.addr[`RP_REG_MSB:`RP_REG_LSB];
  assign cs     = {{(`RP_REGIONS-1){1'b0}}, 1'b1} << region;

  // address and data go everywhere, strobes only to the selected slave
  always_comb
  begin
    hk_req_o      = sys_req_i;
    hk_req_o.wen  = sys_req_i.wen & cs[`RP_REG_HK];
    hk_req_o.ren  = sys_req_i.ren & cs[`RP_REG_HK];
    lvl_req_o     = sys_req_i;
    lvl_req_o.wen = sys_req_i.wen & cs[`RP_REG_LVL];
    lvl_req_o.ren = sys_req_i.ren & cs[`RP_REG_LVL];
    ctl_req_o     = sys_req_i;
    ctl_req_o.wen = sys_req_i.wen & cs[`RP_REG_CTL];
    ctl_req_o.ren = sys_req_i.ren & cs[`RP_REG_CTL];
  end

  // unused regions ack in the same cycle with zero data
  always_comb
  begin
    for (int r = 0; r < `RP_REGIONS; r++)
    begin
      rsp[r].rdata = '0;
      rsp[r].err   = 1'b0;
      rsp[r].ack   = sys_req_i.wen | sys_req_i.ren;
    end
    rsp[`RP_REG_HK]  = hk_rsp_i;
    rsp[`RP_REG_LVL] = lvl_rsp_i;
    rsp[`RP_REG_CTL] = ctl_rsp_i;
  end

  assign sys_rsp_o = rsp[region];   // follows the current address

endmodule : rp_sys_decoder

/* rp_top.sv */
// ADC clock domain top level
`timescale 1ns/1ps
`include "rp_config.svh"

module rp_top
  import rp_bus_pkg::*, rp_analog_pkg::*;
(
  input  logic              adc_clk,
  input  logic              arst_n_i,
  input  logic [`RP_DW-1:0] adc_dat_a_i,   // ADC CH1, neg slope
  input  logic [`RP_DW-1:0] adc_dat_b_i,   // ADC CH2
  output logic [`RP_DW-1:0] dac_dat_a_o,   // DAC CH1, neg slope
  output logic [`RP_DW-1:0] dac_dat_b_o,   // DAC CH2
  output logic [7:0]        led_o,
  input  sys_req_t          sys_req_i,
  output sys_rsp_t          sys_rsp_o
);

  ////////////////////////////////////////
  // bus
  ////////////////////////////////////////
  sys_req_t   hk_req, lvl_req, ctl_req;
  sys_rsp_t   hk_rsp, lvl_rsp, ctl_rsp;

  // data path
  raw_pair_t  adc_raw, dac_raw;    // pin side
  chan_pair_t adc_smp;             // front end out
  chan_pair_t lvl, ctl, dac_sum;
  logic       digital_loop;

  assign adc_raw     = '{a: adc_dat_a_i, b: adc_dat_b_i};
  assign dac_dat_a_o = dac_raw.a;
  assign dac_dat_b_o = dac_raw.b;

  rp_sys_decoder i_dec (
    .sys_req_i (sys_req_i), .sys_rsp_o (sys_rsp_o),
    .hk_req_o  (hk_req),    .hk_rsp_i  (hk_rsp),
    .lvl_req_o (lvl_req),   .lvl_rsp_i (lvl_rsp),
    .ctl_req_o (ctl_req),   .ctl_rsp_i (ctl_rsp)
  );

  rp_housekeeping i_hk (
    .adc_clk, .arst_n_i,
    .sys_req_i (hk_req), .sys_rsp_o (hk_rsp),
    .led_o, .digital_loop_o (digital_loop)
  );

  rp_level_gen i_lvl (
    .adc_clk, .arst_n_i,
    .sys_req_i (lvl_req), .sys_rsp_o (lvl_rsp),
    .level_o   (lvl)      // stands in for the ASG
  );

  rp_prop_ctrl i_ctl (
    .adc_clk, .arst_n_i,
    .sys_req_i (ctl_req), .sys_rsp_o (ctl_rsp),
    .sample_i  (adc_smp), .ctrl_o    (ctl)
  );

  ////////////////////////////////////////
  // analog front and back end
  ////////////////////////////////////////
  rp_adc_frontend i_adc (
    .adc_clk, .arst_n_i,
    .raw_i (adc_raw), .loop_i (dac_sum),   // loop-back from unregistered sum
    .digital_loop_i (digital_loop), .sample_o (adc_smp)
  );

  rp_dac_backend i_dac (
    .adc_clk, .arst_n_i,
    .level_i (lvl), .ctrl_i (ctl),
    .sum_o   (dac_sum), .raw_o (dac_raw)
  );

endmodule : rp_top

/* sim.f */
+incdir+.
rp_bus_pkg.sv
rp_analog_pkg.sv
rp_sys_decoder.sv
rp_housekeeping.sv
rp_level_gen.sv
rp_prop_ctrl.sv
rp_adc_frontend.sv
rp_dac_backend.sv
rp_top.sv
tb_rp_top.sv

/* tb_rp_top.sv */
// ADC domain top testbench
`timescale 1ns/1ps
`include "rp_config.svh"

module tb_rp_top
  import rp_bus_pkg::*;
();

  localparam int PERIOD    = 20;
  localparam int RST_CYC   = 5;
  localparam int BUS_CYC   = 3;        // worst case per bus access
  localparam int SETTLE    = 5;        // pin drive plus 4 cycles
  localparam int TEST_CYC  = RST_CYC + (3 * BUS_CYC + 1) + 30 * BUS_CYC
                             + (2 * BUS_CYC + 4 * (2 * BUS_CYC + SETTLE))
                             + 20 * (6 * BUS_CYC + SETTLE)
                             + (20 * BUS_CYC + 6 * SETTLE);
  localparam int MARGIN_NS = 2000;

  logic        adc_clk;
  logic        arst_n;
  logic [13:0] adc_a, adc_b;   // pin codes with neg slope
  logic [13:0] dac_a, dac_b;
  logic [7:0]  led;
  sys_req_t    req;
  sys_rsp_t    rsp;
  logic [31:0] rng_state;

  rp_top UUT (
    .adc_clk (adc_clk), .arst_n_i (arst_n),
    .adc_dat_a_i (adc_a), .adc_dat_b_i (adc_b),
    .dac_dat_a_o (dac_a), .dac_dat_b_o (dac_b),
    .led_o (led), .sys_req_i (req), .sys_rsp_o (rsp)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #(PERIOD / 2) adc_clk = ~adc_clk;
  end

  // watchdog
  initial
  begin
    #(TEST_CYC * PERIOD + MARGIN_NS);
    $display("watchdog expired, the tests did not complete in time");
    stop_with_failure();
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  task automatic stop_with_failure();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  function automatic logic [31:0] next_rand();   // xorshift32
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [31:0] sign_extend(input logic [31:0] v, input int w);
    int t;
    t = v << (32 - w);
    return t >>> (32 - w);
  endfunction

  function automatic int rand_signed(input int w);
    return sign_extend(next_rand() & ((1 << w) - 1), w);
  endfunction

  function automatic logic [31:0] reg_addr(input int region, input int ofs);
    return (region << 20) | ofs;   // region on bits 22..20
  endfunction

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  function automatic int pin_to_int(input logic [13:0] pin);
    return sign_extend(pin ^ 14'h1FFF, 14);   // msb kept and the rest inverted
  endfunction

  function automatic logic [13:0] int_to_pin(input int v);
    return v[13:0] ^ 14'h1FFF;
  endfunction

  function automatic int clamp14(input int v);
    if (v > 8191)
      return 8191;
    else if (v < -8192)
      return -8192;
    return v;
  endfunction

  // level plus saturated P term as a DAC pin code
  function automatic logic [13:0] model_dac(input int sp, input logic [13:0] pin,
                                            input int kp, input int lvl);
    int err;
    int p;
    err = sp - pin_to_int(pin);
    p   = clamp14((err * kp) >>> 8);   // 8 fraction bits in the gain
    return int_to_pin(clamp14(lvl + p));
  endfunction

  ////////////////////////////////////////
  // bus and pin tasks
  ////////////////////////////////////////
  task automatic bus_xfer(input logic [31:0] addr, input logic [31:0] wdata,
                          input logic wr, output logic [31:0] rdata);
    int lat;
    int exp_lat;
    int region;
    region  = addr[22:20];
    exp_lat = (region == 0 || region == 2 || region == 3) ? 1 : 0;   // unused acks at once
    lat     = -1;
    rdata   = '0;
    @(negedge adc_clk);
    req.addr  = addr;
    req.wdata = wdata;
    req.wen   = wr;
    req.ren   = !wr;
    for (int n = 0; n <= 4 && lat < 0; n++)
    begin
      if (n > 0)
      begin
        @(negedge adc_clk);
        req.wen = 1'b0;   // single cycle strobe
        req.ren = 1'b0;
      end
      #(PERIOD / 4);      // mid low phase
      if (rsp.ack)
      begin
        lat   = n;
        rdata = rsp.rdata;
        check_eq("sys_rsp_o.err", rsp.err, 1'b0);
      end
    end
    if (lat < 0)
    begin
      $display("no bus acknowledge within 4 cycles for address 0x%0h", addr);
      stop_with_failure();
    end
    check_eq("ack latency", lat, exp_lat);
    if (req.wen || req.ren)
    begin
      @(negedge adc_clk);
      req.wen = 1'b0;
      req.ren = 1'b0;
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    bus_xfer(addr, wdata, 1'b1, unused);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
    bus_xfer(addr, '0, 1'b0, rdata);
  endtask

  task automatic write_read_check(input string name, input logic [31:0] addr,
                                  input logic [31:0] wdata, input logic [31:0] exp);
    logic [31:0] d;
    bus_write(addr, wdata);
    bus_read(addr, d);
    check_eq(name, d, exp);
  endtask

  // new pin codes then wait for the 3 stage path
  task automatic drive_adc_and_settle(input logic [13:0] a, input logic [13:0] b);
    @(negedge adc_clk);
    adc_a = a;
    adc_b = b;
    repeat (4) @(negedge adc_clk);
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////
  task automatic test_reset_state();
    logic [31:0] d;
    check_eq("dac_dat_a_o", dac_a, 14'h1FFF);   // zero code
    check_eq("dac_dat_b_o", dac_b, 14'h1FFF);
    check_eq("led_o", led, 8'h00);
    bus_read(reg_addr(0, 'h00), d);
    check_eq("hk id", d, `RP_HK_ID);
    write_read_check("hk id after write", reg_addr(0, 'h00), 32'hDEAD_BEEF, `RP_HK_ID);
  endtask

  task automatic test_register_access();
    logic [31:0] d;
    int          unused_regions [5] = '{1, 4, 5, 6, 7};
    write_read_check("hk loop", reg_addr(0, 'h04), 32'h1, 32'h1);
    bus_write(reg_addr(0, 'h04), 32'h0);
    write_read_check("hk led", reg_addr(0, 'h08), 32'hFFFF_FFA5, 32'hA5);
    check_eq("led_o", led, 8'hA5);
    // levels keep 14 bits and read back sign extended
    write_read_check("level a", reg_addr(2, 'h00), 32'h1234_2ABC, 32'hFFFF_EABC);
    write_read_check("level b", reg_addr(2, 'h04), 32'h0000_1234, 32'h0000_1234);
    write_read_check("setpoint a", reg_addr(3, 'h00), 32'h0000_2345, 32'hFFFF_E345);
    write_read_check("gain a", reg_addr(3, 'h04), 32'h0000_0800, 32'hFFFF_F800);
    write_read_check("setpoint b", reg_addr(3, 'h08), 32'h0000_0FED, 32'h0000_0FED);
    write_read_check("gain b", reg_addr(3, 'h0C), 32'hABCD_07FF, 32'h0000_07FF);
    bus_read(reg_addr(0, 'h0C), d);
    check_eq("hk undefined offset", d, 0);
    bus_read(reg_addr(2, 'h08), d);
    check_eq("level undefined offset", d, 0);
    bus_read(reg_addr(3, 'h10), d);
    check_eq("ctrl undefined offset", d, 0);
    foreach (unused_regions[i])
      write_read_check("unused region", reg_addr(unused_regions[i], 0), 32'hFFFF_FFFF, 0);
  endtask

  task automatic test_level_passthrough();
    int la;
    int lb;
    bus_write(reg_addr(3, 'h04), 0);   // gains off
    bus_write(reg_addr(3, 'h0C), 0);
    repeat (4)
    begin
      la = rand_signed(14);
      lb = rand_signed(14);
      bus_write(reg_addr(2, 'h00), la);
      bus_write(reg_addr(2, 'h04), lb);
      drive_adc_and_settle(next_rand(), next_rand());   // pins must not matter
      check_eq("dac_dat_a_o", dac_a, int_to_pin(la));
      check_eq("dac_dat_b_o", dac_b, int_to_pin(lb));
    end
  endtask

  task automatic test_random_model();
    int          spa, spb, kpa, kpb, la, lb;
    logic [13:0] pa, pb;
    for (int i = 0; i < 20; i++)
    begin
      spa = rand_signed(14);
      spb = rand_signed(14);
      kpa = rand_signed(12);
      kpb = rand_signed(12);
      la  = rand_signed(14);
      lb  = rand_signed(14);
      pa  = next_rand();
      pb  = next_rand();
      if (i == 0)
      begin
        // both stages clip high on a and low on b
        spa = 8191;
        pa  = 14'h3FFF;
        kpa = 2047;
        la  = 8191;
        spb = -8192;
        pb  = 14'h0000;
        kpb = 2047;
        lb  = -8192;
      end
      bus_write(reg_addr(3, 'h00), spa);
      bus_write(reg_addr(3, 'h04), kpa);
      bus_write(reg_addr(3, 'h08), spb);
      bus_write(reg_addr(3, 'h0C), kpb);
      bus_write(reg_addr(2, 'h00), la);
      bus_write(reg_addr(2, 'h04), lb);
      drive_adc_and_settle(pa, pb);
      check_eq("dac_dat_a_o", dac_a, model_dac(spa, pa, kpa, la));
      check_eq("dac_dat_b_o", dac_b, model_dac(spb, pb, kpb, lb));
    end
  endtask

  task automatic test_digital_loop();
    int          spa, spb, kpa, kpb, la, lb;
    logic [13:0] pa, pb;
    la = rand_signed(14);
    lb = rand_signed(14);
    bus_write(reg_addr(3, 'h04), 0);
    bus_write(reg_addr(3, 'h0C), 0);
    bus_write(reg_addr(2, 'h00), la);
    bus_write(reg_addr(2, 'h04), lb);
    bus_write(reg_addr(0, 'h04), 1);    // loop on
    repeat (3)
    begin
      drive_adc_and_settle(next_rand(), next_rand());
      check_eq("dac_dat_a_o", dac_a, int_to_pin(la));
      check_eq("dac_dat_b_o", dac_b, int_to_pin(lb));
    end
    // zero setpoints and levels hold the closed loop at zero for any gain
    bus_write(reg_addr(2, 'h00), 0);
    bus_write(reg_addr(2, 'h04), 0);
    bus_write(reg_addr(3, 'h00), 0);
    bus_write(reg_addr(3, 'h08), 0);
    bus_write(reg_addr(3, 'h04), 1024);
    bus_write(reg_addr(3, 'h0C), -1024);
    drive_adc_and_settle(next_rand(), next_rand());   // pins would show through the gain
    check_eq("dac_dat_a_o", dac_a, int_to_pin(0));
    check_eq("dac_dat_b_o", dac_b, int_to_pin(0));
    bus_write(reg_addr(0, 'h04), 0);    // back to the pins
    spa = rand_signed(14);
    spb = rand_signed(14);
    kpa = rand_signed(12);
    kpb = rand_signed(12);
    pa  = next_rand();
    pb  = next_rand();
    bus_write(reg_addr(3, 'h00), spa);
    bus_write(reg_addr(3, 'h04), kpa);
    bus_write(reg_addr(3, 'h08), spb);
    bus_write(reg_addr(3, 'h0C), kpb);
    bus_write(reg_addr(2, 'h00), la);
    bus_write(reg_addr(2, 'h04), lb);
    drive_adc_and_settle(pa, pb);
    check_eq("dac_dat_a_o", dac_a, model_dac(spa, pa, kpa, la));
    check_eq("dac_dat_b_o", dac_b, model_dac(spb, pb, kpb, lb));
  endtask

  initial
  begin
    req       = '0;
    adc_a     = '0;
    adc_b     = '0;
    arst_n    = 1'b0;
    rng_state = 32'd8;   // seed
    repeat (RST_CYC) @(negedge adc_clk);
    arst_n = 1'b1;
    test_reset_state();
    test_register_access();
    test_level_passthrough();
    test_random_model();
    test_digital_loop();
    $display("Finished with no errors");
    $finish;
  end

endmodule : tb_rp_top
